/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	// data path and pc width
	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;

	// major opcodes handled by the decoder (instr[6:0])
	typedef enum logic [6:0] {
		opc_op_imm = 7'b0010011, // register-immediate alu
		opc_op     = 7'b0110011, // register-register alu
		opc_branch = 7'b1100011  // conditional branch
	} rv_opcode_e;

	// funct3 encodings, alu group
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// funct3 encodings, branch group (bne/bge/bgeu not supported)
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bltu = 3'b110;

	// funct7 for register-register ops
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // selects sub

	// what kind of work the execute unit does
	typedef enum logic [1:0] {
		op_type_alu,
		op_type_branch,
		op_type_nop
	} op_type_e;

	// alu opcodes, then compare opcodes for branches
	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_slt,
		op_sltu,
		op_eq,
		op_lt,
		op_ltu
	} alu_op_e;

	// registered output of the decoder
	typedef struct packed {
		op_type_e          op_type;
		alu_op_e           op;
		logic [xlen-1:0]   op_a;    // rs1 value
		logic [xlen-1:0]   op_b;    // rs2 value or i-imm
		logic [xlen-1:0]   op_c;    // sign-extended immediate
		reg_addr_t         rd;
		logic              instr_c; // expanded 16-bit instruction
	} decoded_op_t;

	// register file write port
	typedef struct packed {
		reg_addr_t         rd_waddr;
		logic [xlen-1:0]   rd_wdata;
		logic              rd_wen;
	} wb_t;

endpackage

`default_nettype wire

/* src/exec_regfile.sv */
`default_nettype none

module exec_regfile (
	input  wire                            clock,
	input  wire                            reset,
	input  wire exec_pkg::reg_addr_t       rs1_addr,
	input  wire exec_pkg::reg_addr_t       rs2_addr,
	output logic [exec_pkg::xlen-1:0]      rs1_data,
	output logic [exec_pkg::xlen-1:0]      rs2_data,
	input  wire exec_pkg::wb_t             wb
);

	logic [exec_pkg::xlen-1:0] regs [32];
	logic                      wr_en;

	// x0 is never written
	assign wr_en = wb.rd_wen && (wb.rd_waddr != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd_waddr] <= wb.rd_wdata;
		end
	end

	// async read, bypass a write landing on this edge
	always_comb begin
		if (rs1_addr == '0) begin
			rs1_data = '0;
		end else if (wr_en && (wb.rd_waddr == rs1_addr)) begin
			rs1_data = wb.rd_wdata;
		end else begin
			rs1_data = regs[rs1_addr];
		end
	end

	always_comb begin
		if (rs2_addr == '0) begin
			rs2_data = '0;
		end else if (wr_en && (wb.rd_waddr == rs2_addr)) begin
			rs2_data = wb.rd_wdata;
		end else begin
			rs2_data = regs[rs2_addr];
		end
	end

endmodule

`default_nettype wire

/* src/exec_decode.sv */
`default_nettype none

module exec_decode (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            instr_valid, // already qualified by ready
	input  wire                            instr_c,
	input  wire [31:0]                     instr,
	output exec_pkg::reg_addr_t            rs1_addr,
	output exec_pkg::reg_addr_t            rs2_addr,
	input  wire [exec_pkg::xlen-1:0]       rs1_data,
	input  wire [exec_pkg::xlen-1:0]       rs2_data,
	output exec_pkg::decoded_op_t          dec_op,
	output logic                           decode_valid
);

	logic [2:0]                funct3;
	logic [6:0]                funct7;
	logic [exec_pkg::xlen-1:0] imm_i;
	logic [exec_pkg::xlen-1:0] imm_b;
	exec_pkg::alu_op_e         arith_op;
	logic                      arith_ok;
	exec_pkg::decoded_op_t     dec_next;

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// operand reads happen in the accept cycle
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	// funct3 map shared by op and op-imm
	always_comb begin
		arith_ok = 1'b1;
		arith_op = exec_pkg::op_add;
		case (funct3)
			exec_pkg::f3_add:  arith_op = exec_pkg::op_add;
			exec_pkg::f3_slt:  arith_op = exec_pkg::op_slt;
			exec_pkg::f3_sltu: arith_op = exec_pkg::op_sltu;
			exec_pkg::f3_xor:  arith_op = exec_pkg::op_xor;
			exec_pkg::f3_or:   arith_op = exec_pkg::op_or;
			exec_pkg::f3_and:  arith_op = exec_pkg::op_and;
			default:           arith_ok = 1'b0; // shifts
		endcase
	end

	always_comb begin
		dec_next.op_type = exec_pkg::op_type_nop;
		dec_next.op      = exec_pkg::op_add;
		dec_next.op_a    = rs1_data;
		dec_next.op_b    = rs2_data;
		dec_next.op_c    = imm_i;
		dec_next.rd      = instr[11:7];
		dec_next.instr_c = instr_c;

		case (instr[6:0])
			exec_pkg::opc_op: begin
				if (arith_ok && funct7 == exec_pkg::f7_base) begin
					dec_next.op_type = exec_pkg::op_type_alu;
					dec_next.op      = arith_op;
				end else if (funct7 == exec_pkg::f7_alt && funct3 == exec_pkg::f3_add) begin
					dec_next.op_type = exec_pkg::op_type_alu;
					dec_next.op      = exec_pkg::op_sub;
				end
			end
			exec_pkg::opc_op_imm: begin
				dec_next.op_b = imm_i;
				if (arith_ok) begin
					dec_next.op_type = exec_pkg::op_type_alu;
					dec_next.op      = arith_op;
				end
			end
			exec_pkg::opc_branch: begin
				dec_next.op_c = imm_b;
				case (funct3)
					exec_pkg::f3_beq: begin
						dec_next.op_type = exec_pkg::op_type_branch;
						dec_next.op      = exec_pkg::op_eq;
					end
					exec_pkg::f3_blt: begin
						dec_next.op_type = exec_pkg::op_type_branch;
						dec_next.op      = exec_pkg::op_lt;
					end
					exec_pkg::f3_bltu: begin
						dec_next.op_type = exec_pkg::op_type_branch;
						dec_next.op      = exec_pkg::op_ltu;
					end
					default: ; // bne/bge/bgeu fall to nop
				endcase
			end
			default: ; // anything else is a no-op
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decode_valid <= 1'b0;
		end else begin
			decode_valid <= instr_valid;
		end
	end

	// held until the next accepted instruction
	always_ff @(posedge clock) begin
		if (instr_valid) begin
			dec_op <= dec_next;
		end
	end

endmodule

`default_nettype wire

/* src/exec_alu.sv */
`default_nettype none

module exec_alu (
	input  wire exec_pkg::alu_op_e         op,
	input  wire [exec_pkg::xlen-1:0]       op_a,
	input  wire [exec_pkg::xlen-1:0]       op_b,
	output logic [exec_pkg::xlen-1:0]      alu_result,
	output logic                           cmp_true
);

	localparam int w = exec_pkg::xlen;

	logic [w:0]   diff;  // extra bit is the borrow
	logic [w-1:0] sum;
	logic         lt_u;
	logic         lt_s;
	logic         eq;

	assign sum  = op_a + op_b;
	assign diff = {1'b0, op_a} - {1'b0, op_b};

	// one subtractor serves sub, slt/sltu and blt/bltu
	assign lt_u = diff[w];
	// signs differ: the negative operand is the smaller one
	assign lt_s = (op_a[w-1] ^ op_b[w-1]) ? op_a[w-1] : diff[w];
	assign eq   = (op_a == op_b);

	always_comb begin
		case (op)
			exec_pkg::op_add:  alu_result = sum;
			exec_pkg::op_sub:  alu_result = diff[w-1:0];
			exec_pkg::op_and:  alu_result = op_a & op_b;
			exec_pkg::op_or:   alu_result = op_a | op_b;
			exec_pkg::op_xor:  alu_result = op_a ^ op_b;
			exec_pkg::op_slt:  alu_result = {{(w-1){1'b0}}, lt_s};
			exec_pkg::op_sltu: alu_result = {{(w-1){1'b0}}, lt_u};
			default:           alu_result = diff[w-1:0]; // compare ops, result unused
		endcase
	end

	always_comb begin
		case (op)
			exec_pkg::op_eq:  cmp_true = eq;
			exec_pkg::op_lt:  cmp_true = lt_s;
			exec_pkg::op_ltu: cmp_true = lt_u;
			default:          cmp_true = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`default_nettype none

module exec_unit #(
	parameter logic [exec_pkg::xlen-1:0] reset_vector = 32'h0000_0000
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            instr_valid,
	output logic                           ready,
	input  wire exec_pkg::decoded_op_t     dec_op,
	input  wire                            decode_valid,
	output exec_pkg::alu_op_e              op,
	output logic [exec_pkg::xlen-1:0]      op_a,
	output logic [exec_pkg::xlen-1:0]      op_b,
	input  wire [exec_pkg::xlen-1:0]       alu_result,
	input  wire                            cmp_true,
	output logic                           instr_complete,
	output logic [exec_pkg::xlen-1:0]      pc,
	output logic                           pc_seq,
	output exec_pkg::wb_t                  wb
);

	typedef enum logic [1:0] {
		st_idle,
		st_decode,  // decode_valid cycle, alu evaluates
		st_execute  // completion cycle, next issue allowed
	} state_e;

	state_e                    state;
	logic                      taken;
	logic                      wr_ok;
	logic [exec_pkg::xlen-1:0] pc_next;
	exec_pkg::reg_addr_t       wb_waddr;
	logic [exec_pkg::xlen-1:0] wb_wdata;
	logic                      wb_wen;

	assign ready = (state != st_decode);

	assign op   = dec_op.op;
	assign op_a = dec_op.op_a;
	assign op_b = dec_op.op_b;

	assign taken   = (dec_op.op_type == exec_pkg::op_type_branch) && cmp_true;
	assign wr_ok   = (dec_op.op_type == exec_pkg::op_type_alu) && (dec_op.rd != '0);
	assign pc_next = taken ? (pc + dec_op.op_c) : (pc + (dec_op.instr_c ? 32'd2 : 32'd4));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:    if (instr_valid) state <= st_decode;
				st_decode:  if (decode_valid) state <= st_execute;
				st_execute: state <= instr_valid ? st_decode : st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	// completion, pc and write enable all move on the same edge
	always_ff @(posedge clock) begin
		if (reset) begin
			instr_complete <= 1'b0;
			pc             <= reset_vector;
			pc_seq         <= 1'b1;
			wb_wen         <= 1'b0;
		end else begin
			instr_complete <= decode_valid;
			wb_wen         <= decode_valid && wr_ok;
			if (decode_valid) begin
				pc     <= pc_next;
				pc_seq <= !taken;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (decode_valid) begin
			wb_waddr <= dec_op.rd;
			wb_wdata <= alu_result;
		end
	end

	assign wb = '{rd_waddr: wb_waddr, rd_wdata: wb_wdata, rd_wen: wb_wen};

endmodule

`default_nettype wire

/* src/exec_top.sv */
`default_nettype none

module exec_top #(
	parameter logic [exec_pkg::xlen-1:0] reset_vector = 32'h0000_0000
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            instr_valid,
	input  wire [31:0]                     instr,
	input  wire                            instr_c,
	output logic                           ready,
	output logic                           decode_valid,
	output logic                           instr_complete,
	output logic [exec_pkg::xlen-1:0]      pc,
	output logic                           pc_seq,
	output exec_pkg::wb_t                  wb
);

	exec_pkg::reg_addr_t       rs1_addr;
	exec_pkg::reg_addr_t       rs2_addr;
	logic [exec_pkg::xlen-1:0] rs1_data;
	logic [exec_pkg::xlen-1:0] rs2_data;
	exec_pkg::decoded_op_t     dec_op;
	exec_pkg::alu_op_e         op;
	logic [exec_pkg::xlen-1:0] op_a;
	logic [exec_pkg::xlen-1:0] op_b;
	logic [exec_pkg::xlen-1:0] alu_result;
	logic                      cmp_true;
	wire                       issue = instr_valid & ready; // strobes while busy are dropped

	exec_decode decode_i (
		.clock        (clock),
		.reset        (reset),
		.instr_valid  (issue),
		.instr_c      (instr_c),
		.instr        (instr),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.dec_op       (dec_op),
		.decode_valid (decode_valid)
	);

	exec_regfile regfile_i (
		.clock    (clock),
		.reset    (reset),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb)
	);

	exec_alu alu_i (
		.op         (op),
		.op_a       (op_a),
		.op_b       (op_b),
		.alu_result (alu_result),
		.cmp_true   (cmp_true)
	);

	exec_unit #(
		.reset_vector (reset_vector)
	) unit_i (
		.clock          (clock),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.ready          (ready),
		.dec_op         (dec_op),
		.decode_valid   (decode_valid),
		.op             (op),
		.op_a           (op_a),
		.op_b           (op_b),
		.alu_result     (alu_result),
		.cmp_true       (cmp_true),
		.instr_complete (instr_complete),
		.pc             (pc),
		.pc_seq         (pc_seq),
		.wb             (wb)
	);

endmodule

`default_nettype wire

/* verif/exec_branch_checker.sv */
`default_nettype none

module exec_branch_checker (
	input wire                             clock,
	input wire                             reset,
	input wire                             decode_valid,
	input wire                             instr_complete,
	input wire exec_pkg::decoded_op_t      dec_op,
	input wire [exec_pkg::xlen-1:0]        pc,
	input wire                             pc_seq,
	input wire exec_pkg::wb_t              wb
);

	exec_pkg::decoded_op_t     held_op;   // operation that is about to complete
	logic [exec_pkg::xlen-1:0] held_pc;   // pc before completion
	logic                      is_branch;
	logic                      is_cmp;
	logic                      exp_taken;
	logic [exec_pkg::xlen-1:0] exp_pc;
	int                        fail_count = 0;

	always_ff @(posedge clock) begin
		if (decode_valid) begin
			held_op <= dec_op;
			held_pc <= pc;
		end
	end

	assign is_branch = (held_op.op_type == exec_pkg::op_type_branch);
	assign is_cmp    = (held_op.op == exec_pkg::op_eq) || (held_op.op == exec_pkg::op_lt)
		|| (held_op.op == exec_pkg::op_ltu);

	// branch rule on the held operands
	always_comb begin
		case (held_op.op)
			exec_pkg::op_eq:  exp_taken = (held_op.op_a == held_op.op_b);
			exec_pkg::op_lt:  exp_taken = ($signed(held_op.op_a) < $signed(held_op.op_b));
			exec_pkg::op_ltu: exp_taken = (held_op.op_a < held_op.op_b);
			default:          exp_taken = 1'b0;
		endcase
	end

	assign exp_pc = exp_taken ? (held_pc + held_op.op_c)
		: (held_pc + (held_op.instr_c ? 32'd2 : 32'd4));

	branch_op_a: assert property (@(posedge clock) disable iff (reset)
		(instr_complete && is_branch) |-> is_cmp)
		else begin
			fail_count++;
			$error("branch completed with a non-compare opcode");
		end

	branch_pc_a: assert property (@(posedge clock) disable iff (reset)
		(instr_complete && is_branch) |-> (pc == exp_pc) && (pc_seq == !exp_taken))
		else begin
			fail_count++;
			$error("branch target or pc_seq wrong: pc %h, expected %h", pc, exp_pc);
		end

	no_x0_write_a: assert property (@(posedge clock) disable iff (reset)
		wb.rd_wen |-> (wb.rd_waddr != 5'd0))
		else begin
			fail_count++;
			$error("write-back enabled for x0");
		end

	no_branch_write_a: assert property (@(posedge clock) disable iff (reset)
		(instr_complete && is_branch) |-> !wb.rd_wen)
		else begin
			fail_count++;
			$error("write-back enabled for a branch");
		end

	complete_after_decode_a: assert property (@(posedge clock) disable iff (reset)
		decode_valid |=> instr_complete)
		else begin
			fail_count++;
			$error("instr_complete missing one cycle after decode_valid");
		end

	complete_needs_decode_a: assert property (@(posedge clock) disable iff (reset)
		instr_complete |-> $past(decode_valid))
		else begin
			fail_count++;
			$error("instr_complete without decode_valid in the cycle before");
		end

endmodule

`default_nettype wire

/* verif/exec_tb.sv */
`default_nettype none

module exec_tb;

	localparam logic [31:0] reset_vector = 32'h0000_1000;
	// instructions per test: reset, alu, branch, pc step, x0, busy/nop
	localparam int n_instr     = 1 + 91 + 23 + 4 + 4 + 5;
	localparam int cycle_limit = n_instr * 3 + 60;

	logic          clock;
	logic          reset;
	logic          instr_valid;
	logic [31:0]   instr;
	logic          instr_c;
	logic          ready;
	logic          decode_valid;
	logic          instr_complete;
	logic [31:0]   pc;
	logic          pc_seq;
	exec_pkg::wb_t wb;

	logic [31:0]   shadow [32]; // expected register file
	logic [31:0]   shadow_pc;
	int            seed;
	int            errors;
	int            test_errors;
	int            tests_run;
	int            checker_fails;
	int            cycle_count;

	exec_top #(
		.reset_vector (reset_vector)
	) dut_i (
		.clock          (clock),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.instr_c        (instr_c),
		.ready          (ready),
		.decode_valid   (decode_valid),
		.instr_complete (instr_complete),
		.pc             (pc),
		.pc_seq         (pc_seq),
		.wb             (wb)
	);

	bind exec_top exec_branch_checker branch_checker_i (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.instr_complete (instr_complete),
		.dec_op         (dec_op),
		.pc             (pc),
		.pc_seq         (pc_seq),
		.wb             (wb)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the DUT stopped completing instructions", cycle_count);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] itype(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		itype = {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] rtype(input logic sub, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		rtype = {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		btype = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	// reference alu, straight from the isa rules
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  alu_model = sub ? a - b : a + b;
			3'b010:  alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  alu_model = (a < b) ? 32'd1 : 32'd0;
			3'b100:  alu_model = a ^ b;
			3'b110:  alu_model = a | b;
			3'b111:  alu_model = a & b;
			default: alu_model = 32'd0;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("at time %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		$display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
		tests_run++;
		test_errors = 0;
	endtask

	// drive one word, optionally a stray strobe while busy, then wait for completion
	task automatic issue_instr(input logic [31:0] word, input logic compressed,
			input logic inject, input logic [31:0] stray);
		int cycles;
		while (!ready) @(negedge clock);
		instr       = word;
		instr_c     = compressed;
		instr_valid = 1'b1;
		@(negedge clock);
		cycles      = 1;
		instr_valid = inject;
		instr       = stray;
		assert (decode_valid) else report_problem("decode_valid did not pulse after accept");
		assert (!ready) else report_problem("ready high in the decode cycle");
		while (!instr_complete && cycles < 6) begin
			@(negedge clock);
			instr_valid = 1'b0;
			cycles++;
		end
		instr_valid = 1'b0;
		assert (cycles == 2) else report_mismatch("latency", 32'(cycles), 32'd2);
		assert (ready) else report_problem("ready still low when the instruction completed");
	endtask

	// compare write-back and pc with the model, then advance the model
	task automatic check_result(input logic [31:0] word, input logic compressed);
		logic [6:0]  opcode;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] result;
		logic        wen;
		logic        taken;
		logic [31:0] next_pc;
		opcode = word[6:0];
		f3     = word[14:12];
		f7     = word[31:25];
		rd     = word[11:7];
		a      = shadow[word[19:15]];
		b      = shadow[word[24:20]];
		imm_i  = {{20{word[31]}}, word[31:20]};
		imm_b  = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
		wen    = 1'b0;
		taken  = 1'b0;
		result = 32'd0;
		// shift funct3 values are outside the subset
		if (opcode == 7'b0110011 && f3 != 3'b001 && f3 != 3'b101
				&& (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
			wen    = 1'b1;
			result = alu_model(f3, f7[5], a, b);
		end else if (opcode == 7'b0010011 && f3 != 3'b001 && f3 != 3'b101) begin
			wen    = 1'b1;
			result = alu_model(f3, 1'b0, a, imm_i);
		end else if (opcode == 7'b1100011) begin
			case (f3)
				3'b000:  taken = (a == b);
				3'b100:  taken = ($signed(a) < $signed(b));
				3'b110:  taken = (a < b);
				default: taken = 1'b0;
			endcase
		end
		wen     = wen && (rd != 5'd0);
		next_pc = taken ? shadow_pc + imm_b : shadow_pc + (compressed ? 32'd2 : 32'd4);
		assert (wb.rd_wen == wen) else report_mismatch("wb.rd_wen", 32'(wb.rd_wen), 32'(wen));
		if (wen) begin
			assert (wb.rd_waddr == rd)
				else report_mismatch("wb.rd_waddr", 32'(wb.rd_waddr), 32'(rd));
			assert (wb.rd_wdata == result) else report_mismatch("wb.rd_wdata", wb.rd_wdata, result);
			shadow[rd] = result;
		end
		assert (pc == next_pc) else report_mismatch("pc", pc, next_pc);
		assert (pc_seq == !taken) else report_mismatch("pc_seq", 32'(pc_seq), 32'(!taken));
		shadow_pc = next_pc;
	endtask

	task automatic run_instr(input logic [31:0] word, input logic compressed);
		issue_instr(word, compressed, 1'b0, 32'd0);
		check_result(word, compressed);
	endtask

	task automatic check_reset_state();
		assert (ready == 1'b1) else report_mismatch("ready", 32'(ready), 32'd1);
		assert (decode_valid == 1'b0)
			else report_mismatch("decode_valid", 32'(decode_valid), 32'd0);
		assert (instr_complete == 1'b0)
			else report_mismatch("instr_complete", 32'(instr_complete), 32'd0);
		assert (wb.rd_wen == 1'b0) else report_mismatch("wb.rd_wen", 32'(wb.rd_wen), 32'd0);
		assert (pc == reset_vector) else report_mismatch("pc", pc, reset_vector);
		run_instr(itype(3'b000, 5'd1, 5'd0, 12'h123), 1'b0);
		end_test("reset and latency");
	endtask

	task automatic alu_sweep();
		logic [2:0] alu_f3 [6];
		logic [2:0] f3;
		logic       sub;
		alu_f3 = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
		for (int r = 1; r < 32; r++) begin
			run_instr(itype(3'b000, 5'(r), 5'd0, 12'($random(seed))), 1'b0);
		end
		for (int i = 0; i < 60; i++) begin
			f3  = alu_f3[{$random(seed)} % 6];
			sub = (f3 == 3'b000) && 1'($random(seed));
			if (1'($random(seed))) begin
				run_instr(rtype(sub, f3, 5'($random(seed)), 5'($random(seed)),
					5'($random(seed))), 1'b0);
			end else begin
				run_instr(itype(f3, 5'($random(seed)), 5'($random(seed)),
					12'($random(seed))), 1'($random(seed)));
			end
		end
		end_test("alu ops");
	endtask

	task automatic branch_cases();
		logic [2:0] br_f3 [3];
		br_f3 = '{3'b000, 3'b100, 3'b110};
		run_instr(itype(3'b000, 5'd1, 5'd0, 12'hfff), 1'b0); // x1 = -1
		run_instr(itype(3'b000, 5'd2, 5'd0, 12'h001), 1'b0);
		run_instr(itype(3'b000, 5'd3, 5'd0, 12'h001), 1'b0);
		run_instr(btype(3'b000, 5'd2, 5'd3, 13'h0010), 1'b0); // equal, taken
		run_instr(btype(3'b000, 5'd1, 5'd2, 13'h0020), 1'b1);
		run_instr(btype(3'b100, 5'd1, 5'd2, 13'h1ff0), 1'b0); // -1 < 1 signed
		run_instr(btype(3'b110, 5'd1, 5'd2, 13'h0040), 1'b0); // but not unsigned
		run_instr(btype(3'b100, 5'd2, 5'd1, 13'h0008), 1'b1);
		run_instr(btype(3'b110, 5'd2, 5'd1, 13'h1ffc), 1'b0);
		run_instr(btype(3'b100, 5'd2, 5'd3, 13'h0100), 1'b0);
		run_instr(btype(3'b110, 5'd2, 5'd3, 13'h0100), 1'b1);
		for (int i = 0; i < 12; i++) begin
			run_instr(btype(br_f3[{$random(seed)} % 3], 5'({$random(seed)} % 4),
				5'({$random(seed)} % 4), 13'($random(seed)) & 13'h1ffe), 1'($random(seed)));
		end
		end_test("branches");
	endtask

	task automatic pc_step_cases();
		logic [31:0] start;
		start = shadow_pc;
		run_instr(itype(3'b000, 5'd4, 5'd4, 12'h010), 1'b1);
		assert (pc == start + 32'd2) else report_mismatch("pc", pc, start + 32'd2);
		run_instr(itype(3'b000, 5'd4, 5'd4, 12'h010), 1'b0);
		run_instr(btype(3'b000, 5'd1, 5'd2, 13'h0080), 1'b1); // not taken
		start = shadow_pc;
		run_instr(btype(3'b000, 5'd1, 5'd2, 13'h0080), 1'b0);
		assert (pc == start + 32'd4) else report_mismatch("pc", pc, start + 32'd4);
		end_test("pc step");
	endtask

	task automatic x0_cases();
		run_instr(itype(3'b000, 5'd0, 5'd1, 12'h7ff), 1'b0);
		run_instr(rtype(1'b0, 3'b000, 5'd0, 5'd1, 5'd2), 1'b0);
		run_instr(rtype(1'b0, 3'b110, 5'd7, 5'd0, 5'd2), 1'b0); // x0 reads as zero
		run_instr(itype(3'b000, 5'd8, 5'd0, 12'h000), 1'b0);
		end_test("x0 writes");
	endtask

	task automatic busy_and_nop_cases();
		logic [31:0] word;
		word = itype(3'b000, 5'd9, 5'd0, 12'h055);
		issue_instr(word, 1'b0, 1'b1, itype(3'b000, 5'd9, 5'd0, 12'h0aa));
		check_result(word, 1'b0);
		repeat (2) begin
			@(negedge clock);
			assert (!decode_valid && !instr_complete)
				else report_problem("strobe during busy cycle was accepted");
		end
		assert (pc == shadow_pc) else report_mismatch("pc", pc, shadow_pc);
		run_instr(rtype(1'b0, 3'b110, 5'd10, 5'd9, 5'd0), 1'b0); // x9 kept first value
		run_instr({20'habcde, 5'd11, 7'b0110111}, 1'b0);         // lui
		run_instr(btype(3'b001, 5'd1, 5'd2, 13'h0010), 1'b0);    // bne
		run_instr(itype(3'b001, 5'd12, 5'd1, 12'h004), 1'b1);    // slli
		end_test("busy strobe and no-ops");
	endtask

	initial begin
		seed        = 32'h4845a158;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = 32'd0;
		instr_c     = 1'b0;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = 32'd0;
		end
		shadow_pc = reset_vector;
		repeat (5) @(negedge clock);
		reset = 1'b0;

		check_reset_state();
		alu_sweep();
		branch_cases();
		pc_step_cases();
		x0_cases();
		busy_and_nop_cases();

		checker_fails = dut_i.branch_checker_i.fail_count;
		$display("%0d tests, %0d check errors, %0d checker assertion failures",
			tests_run, errors, checker_fails);
		if (errors == 0 && checker_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/exec_pkg.sv
src/exec_regfile.sv
src/exec_decode.sv
src/exec_alu.sv
src/exec_unit.sv
src/exec_top.sv
verif/exec_branch_checker.sv
verif/exec_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module exec_tb -f build.f -o exec_sim \
	&& ./obj_dir/exec_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
